// File: bus_pkg.sv
// Bus widths and MMIO address map, shared by the decoder and every peripheral
package bus_pkg;

    // ========================================================================
    // Bus widths
    // ========================================================================
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = 4;                   // One strobe per byte lane

    // ========================================================================
    // Address map
    // ========================================================================
    // Peripheral windows are 16-byte pages
    localparam logic [ADDR_WIDTH-5:0] PAGE_UART  = 28'h8000000;  // 0x80000000 to 0x8000000F
    localparam logic [ADDR_WIDTH-5:0] PAGE_TIMER = 28'h8000002;  // 0x80000020 to 0x8000002F

    // Simple I/O sits on single word addresses
    localparam logic [ADDR_WIDTH-1:0] ADDR_LED_CONTROL  = 32'h80000010;
    localparam logic [ADDR_WIDTH-1:0] ADDR_BUTTON_INPUT = 32'h80000018;
    localparam logic [ADDR_WIDTH-1:0] ADDR_SOFT_IRQ_W   = 32'h80000040;  // Write only

    // Page and register offset view of an address
    typedef struct packed {
        logic [ADDR_WIDTH-5:0] page;                 // Upper 28 bits select the window
        logic [3:0]            offset;               // Register inside the window
    } mmio_page_t;

    // Same bus address read as a full word or as page plus offset
    typedef union packed {
        logic [ADDR_WIDTH-1:0] word;                 // Full word match for simple I/O
        mmio_page_t            fields;               // Window decode and register select
    } mmio_addr_u;

endpackage

// File: periph_pkg.sv
// Peripheral constants for simple I/O, the tick timer and the receive FIFO
package periph_pkg;

    // Simple I/O
    localparam int LED_COUNT    = 2;
    localparam int BUTTON_COUNT = 2;

    // Receive FIFO
    localparam int FIFO_ADDR_BITS = 4;               // 16 entries
    localparam int RX_BYTE_WIDTH  = 8;

    // Tick timer
    localparam logic [31:0] TIMER_DEFAULT_PERIOD = 32'd1000;

    // ========================================================================
    // Register offsets inside a 16-byte window
    // ========================================================================
    localparam logic [3:0] TMR_CTRL   = 4'h0;        // Bit 0 enable
    localparam logic [3:0] TMR_PERIOD = 4'h4;
    localparam logic [3:0] TMR_COUNT  = 4'h8;        // Read only
    localparam logic [3:0] TMR_STATUS = 4'hC;        // Bit 0 pending, write 1 to clear

    localparam logic [3:0] UART_DATA   = 4'h0;       // Oldest received byte, read pops
    localparam logic [3:0] UART_STATUS = 4'h4;

    // UART status word bits
    localparam int UART_STAT_EMPTY = 0;
    localparam int UART_STAT_FULL  = 1;

endpackage

// File: mmio_decode.sv
// MMIO address decoder with per-peripheral selects, response mux and unmapped responder
`timescale 1ns/1ps

module mmio_decode (
    input  logic                           clk,
    input  logic                           global_resetn,
    input  logic                           mmio_valid,
    input  bus_pkg::mmio_addr_u            mmio_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0] simple_rdata,
    input  logic [bus_pkg::DATA_WIDTH-1:0] uart_rdata,
    input  logic [bus_pkg::DATA_WIDTH-1:0] timer_rdata,
    input  logic                           simple_ready,
    input  logic                           uart_ready,
    input  logic                           timer_ready,
    output logic                           sel_simple,
    output logic                           sel_uart,
    output logic                           sel_timer,
    output logic [bus_pkg::DATA_WIDTH-1:0] mmio_rdata,
    output logic                           mmio_ready
);

    logic hit_simple;
    logic hit_uart;
    logic hit_timer;
    logic sel_unmapped;
    logic unmapped_ready;                            // One-cycle ack for holes in the map

    // Address match, no overlap between the three regions
    assign hit_simple = (mmio_addr.word == bus_pkg::ADDR_LED_CONTROL)  ||
                        (mmio_addr.word == bus_pkg::ADDR_BUTTON_INPUT) ||
                        (mmio_addr.word == bus_pkg::ADDR_SOFT_IRQ_W);
    assign hit_uart   = (mmio_addr.fields.page == bus_pkg::PAGE_UART);
    assign hit_timer  = (mmio_addr.fields.page == bus_pkg::PAGE_TIMER);

    // Exactly one select per request
    assign sel_simple   = mmio_valid && hit_simple;
    assign sel_uart     = mmio_valid && hit_uart;
    assign sel_timer    = mmio_valid && hit_timer;
    assign sel_unmapped = mmio_valid && !(hit_simple || hit_uart || hit_timer);

    // ========================================================================
    // Unmapped responder
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!global_resetn) begin
            unmapped_ready <= 1'b0;
        end else begin
            unmapped_ready <= sel_unmapped && !unmapped_ready;  // No repeat while valid held
        end
    end

    // Response mux, address is held through the ready cycle
    assign mmio_rdata = hit_simple ? simple_rdata :
                        hit_uart   ? uart_rdata   :
                        hit_timer  ? timer_rdata  : '0;  // Unmapped reads as zero

    assign mmio_ready = hit_simple ? simple_ready :
                        hit_uart   ? uart_ready   :
                        hit_timer  ? timer_ready  : unmapped_ready;

endmodule

// File: simple_io.sv
// Simple I/O peripheral with LED register, synchronized buttons and software interrupt
`timescale 1ns/1ps

module simple_io (
    input  logic                                  clk,
    input  logic                                  global_resetn,
    input  logic                                  sel,
    input  logic                                  mmio_valid,
    input  logic                                  mmio_write,
    input  bus_pkg::mmio_addr_u                   mmio_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0]        mmio_wdata,
    input  logic [bus_pkg::STRB_WIDTH-1:0]        mmio_wstrb,
    input  logic [periph_pkg::BUTTON_COUNT-1:0]   buttons_n,
    output logic [bus_pkg::DATA_WIDTH-1:0]        rdata,
    output logic                                  ready,
    output logic [periph_pkg::LED_COUNT-1:0]      leds,
    output logic                                  soft_irq
);

    logic [periph_pkg::LED_COUNT-1:0]    led_reg;
    logic [periph_pkg::BUTTON_COUNT-1:0] btn_meta;  // First sync stage
    logic [periph_pkg::BUTTON_COUNT-1:0] btn_sync;  // Pressed reads as 1
    logic                                req;

    assign req  = mmio_valid && sel && !ready;       // Own ready blocks a second ack
    assign leds = led_reg;

    // ========================================================================
    // Button synchronizers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!global_resetn) begin
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= ~buttons_n;                  // Active low pins to active high
            btn_sync <= btn_meta;
        end
    end

    // Control and side effects, all at the ready edge
    always_ff @(posedge clk) begin
        if (!global_resetn) begin
            led_reg  <= '0;
            ready    <= 1'b0;
            soft_irq <= 1'b0;
        end else begin
            ready    <= req;
            soft_irq <= 1'b0;                        // Single-cycle pulse
            if (req && mmio_write) begin
                if (mmio_addr.word == bus_pkg::ADDR_LED_CONTROL && mmio_wstrb[0]) begin
                    led_reg <= mmio_wdata[periph_pkg::LED_COUNT-1:0];
                end
                if (mmio_addr.word == bus_pkg::ADDR_SOFT_IRQ_W) begin
                    soft_irq <= 1'b1;
                end
                // Button address write is acked and dropped
            end
        end
    end

    // Read data
    always_ff @(posedge clk) begin
        if (req && !mmio_write) begin
            rdata <= '0;
            case (mmio_addr.word)
                bus_pkg::ADDR_LED_CONTROL:  rdata[periph_pkg::LED_COUNT-1:0]    <= led_reg;
                bus_pkg::ADDR_BUTTON_INPUT: rdata[periph_pkg::BUTTON_COUNT-1:0] <= btn_sync;
                default: ;                           // Soft IRQ reads back zero
            endcase
        end
    end

endmodule

// File: tick_timer.sv
// Periodic tick timer with programmable period and write-one-to-clear pending interrupt
`timescale 1ns/1ps

module tick_timer (
    input  logic                           clk,
    input  logic                           global_resetn,
    input  logic                           sel,
    input  logic                           mmio_valid,
    input  logic                           mmio_write,
    input  bus_pkg::mmio_addr_u            mmio_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0] mmio_wdata,
    input  logic [bus_pkg::STRB_WIDTH-1:0] mmio_wstrb,
    output logic [bus_pkg::DATA_WIDTH-1:0] rdata,
    output logic                           ready,
    output logic                           timer_irq
);

    logic                           enable;
    logic [bus_pkg::DATA_WIDTH-1:0] period;
    logic [bus_pkg::DATA_WIDTH-1:0] count;
    logic                           pending;
    logic                           req;
    logic                           wr_en;

    assign req       = mmio_valid && sel && !ready;
    assign wr_en     = req && mmio_write;
    assign timer_irq = pending;                      // Level until software clears it

    always_ff @(posedge clk) begin
        if (!global_resetn) begin
            ready   <= 1'b0;
            enable  <= 1'b0;
            period  <= periph_pkg::TIMER_DEFAULT_PERIOD;
            count   <= '0;
            pending <= 1'b0;
        end else begin
            ready <= req;

            // ================================================================
            // Tick, one count per cycle while enabled
            // ================================================================
            if (enable) begin
                if (count == period - 1'b1) begin
                    count   <= '0;                   // Wrap and flag in the same edge
                    pending <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end

            // Register writes, later assignments win over the tick
            if (wr_en) begin
                case (mmio_addr.fields.offset)
                    periph_pkg::TMR_CTRL: begin
                        if (mmio_wstrb[0]) begin
                            enable <= mmio_wdata[0];
                        end
                    end
                    periph_pkg::TMR_PERIOD: begin
                        if (mmio_wstrb[0]) begin
                            period <= mmio_wdata;
                            count  <= '0;            // Restart the interval
                        end
                    end
                    periph_pkg::TMR_STATUS: begin
                        if (mmio_wdata[0]) begin
                            pending <= 1'b0;         // W1C
                        end
                    end
                    default: ;                       // Count is read only
                endcase
            end
        end
    end

    // Read data
    always_ff @(posedge clk) begin
        if (req && !mmio_write) begin
            rdata <= '0;
            case (mmio_addr.fields.offset)
                periph_pkg::TMR_CTRL:   rdata[0] <= enable;
                periph_pkg::TMR_PERIOD: rdata    <= period;
                periph_pkg::TMR_COUNT:  rdata    <= count;
                periph_pkg::TMR_STATUS: rdata[0] <= pending;
                default: ;
            endcase
        end
    end

endmodule

// File: rx_byte_fifo.sv
// Receive byte FIFO filled by rx strobes and drained through the UART MMIO window
`timescale 1ns/1ps

module rx_byte_fifo (
    input  logic                                 clk,
    input  logic                                 global_resetn,
    input  logic                                 sel,
    input  logic                                 mmio_valid,
    input  logic                                 mmio_write,
    input  bus_pkg::mmio_addr_u                  mmio_addr,
    input  logic [periph_pkg::RX_BYTE_WIDTH-1:0] rx_byte,
    input  logic                                 rx_valid,
    output logic [bus_pkg::DATA_WIDTH-1:0]       rdata,
    output logic                                 ready
);

    // Storage
    logic [periph_pkg::RX_BYTE_WIDTH-1:0]  mem [0:(1 << periph_pkg::FIFO_ADDR_BITS)-1];
    logic [periph_pkg::FIFO_ADDR_BITS-1:0] wr_ptr;  // Wraps naturally at depth
    logic [periph_pkg::FIFO_ADDR_BITS-1:0] rd_ptr;
    logic [periph_pkg::FIFO_ADDR_BITS:0]   fill;    // 0 to depth inclusive
    logic                                  empty;
    logic                                  full;
    logic                                  push;
    logic                                  pop;
    logic                                  req;

    assign req   = mmio_valid && sel && !ready;
    assign empty = (fill == '0);
    assign full  = fill[periph_pkg::FIFO_ADDR_BITS];  // MSB set only at depth
    assign push  = rx_valid && !full;                 // Overflow bytes dropped
    assign pop   = req && !mmio_write && !empty &&
                   (mmio_addr.fields.offset == periph_pkg::UART_DATA);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rx_byte;
        end
    end

    // ========================================================================
    // Pointers and occupancy
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!global_resetn) begin
            ready  <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            ready <= req;                            // Writes acked, nothing stored
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;                           // Both or neither
            endcase
        end
    end

    // Read data, sampled at the pop edge
    always_ff @(posedge clk) begin
        if (req && !mmio_write) begin
            rdata <= '0;
            case (mmio_addr.fields.offset)
                periph_pkg::UART_DATA: begin
                    if (!empty) begin
                        rdata[periph_pkg::RX_BYTE_WIDTH-1:0] <= mem[rd_ptr];
                    end
                end
                periph_pkg::UART_STATUS: begin
                    rdata[periph_pkg::UART_STAT_EMPTY] <= empty;
                    rdata[periph_pkg::UART_STAT_FULL]  <= full;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: mmio_subsystem_top.sv
// Top level of the MMIO subsystem, decoder plus simple I/O, tick timer and receive FIFO
`timescale 1ns/1ps

module mmio_subsystem_top (
    input  logic                                 clk,
    input  logic                                 global_resetn,
    input  logic                                 mmio_valid,
    input  logic                                 mmio_write,
    input  logic [bus_pkg::ADDR_WIDTH-1:0]       mmio_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0]       mmio_wdata,
    input  logic [bus_pkg::STRB_WIDTH-1:0]       mmio_wstrb,
    input  logic [periph_pkg::BUTTON_COUNT-1:0]  buttons_n,
    input  logic [periph_pkg::RX_BYTE_WIDTH-1:0] rx_byte,
    input  logic                                 rx_valid,
    output logic [bus_pkg::DATA_WIDTH-1:0]       mmio_rdata,
    output logic                                 mmio_ready,
    output logic [periph_pkg::LED_COUNT-1:0]     leds,
    output logic                                 soft_irq,
    output logic                                 timer_irq
);

    bus_pkg::mmio_addr_u            addr_u;          // Word and page views of the address
    logic                           sel_simple;
    logic                           sel_uart;
    logic                           sel_timer;
    logic [bus_pkg::DATA_WIDTH-1:0] simple_rdata;
    logic [bus_pkg::DATA_WIDTH-1:0] uart_rdata;
    logic [bus_pkg::DATA_WIDTH-1:0] timer_rdata;
    logic                           simple_ready;
    logic                           uart_ready;
    logic                           timer_ready;

    assign addr_u = bus_pkg::mmio_addr_u'(mmio_addr);

    mmio_decode decode_i (
        .clk(clk), .global_resetn(global_resetn),
        .mmio_valid(mmio_valid), .mmio_addr(addr_u),
        .simple_rdata(simple_rdata), .uart_rdata(uart_rdata), .timer_rdata(timer_rdata),
        .simple_ready(simple_ready), .uart_ready(uart_ready), .timer_ready(timer_ready),
        .sel_simple(sel_simple), .sel_uart(sel_uart), .sel_timer(sel_timer),
        .mmio_rdata(mmio_rdata), .mmio_ready(mmio_ready)
    );

    simple_io simple_io_i (
        .clk(clk), .global_resetn(global_resetn), .sel(sel_simple),
        .mmio_valid(mmio_valid), .mmio_write(mmio_write), .mmio_addr(addr_u),
        .mmio_wdata(mmio_wdata), .mmio_wstrb(mmio_wstrb), .buttons_n(buttons_n),
        .rdata(simple_rdata), .ready(simple_ready), .leds(leds), .soft_irq(soft_irq)
    );

    tick_timer timer_i (
        .clk(clk), .global_resetn(global_resetn), .sel(sel_timer),
        .mmio_valid(mmio_valid), .mmio_write(mmio_write), .mmio_addr(addr_u),
        .mmio_wdata(mmio_wdata), .mmio_wstrb(mmio_wstrb),
        .rdata(timer_rdata), .ready(timer_ready), .timer_irq(timer_irq)
    );

    // UART window, receive side only
    rx_byte_fifo rx_fifo_i (
        .clk(clk), .global_resetn(global_resetn), .sel(sel_uart),
        .mmio_valid(mmio_valid), .mmio_write(mmio_write), .mmio_addr(addr_u),
        .rx_byte(rx_byte), .rx_valid(rx_valid),
        .rdata(uart_rdata), .ready(uart_ready)
    );

endmodule

// File: tb_mmio_subsystem.sv
// Table-driven testbench for the MMIO subsystem, compiled together with the RTL from src.f
`timescale 1ns/1ps

module tb_mmio_subsystem;

    // ========================================================================
    // Row operations and address map as seen by the bus master
    // ========================================================================
    localparam int OP_WRITE  = 0;                    // exp bit 0 is soft_irq in ready cycle
    localparam int OP_READ   = 1;
    localparam int OP_PUSH   = 2;                    // data is the byte count
    localparam int OP_BUTTON = 3;
    localparam int OP_WAIT   = 4;
    localparam int OP_POP    = 5;                    // UART data reads against byte model
    localparam int OP_OUTS   = 6;                    // {timer_irq, soft_irq, leds}
    localparam int OP_TIRQ   = 7;                    // timer_irq held for data cycles

    localparam int TIMER_PERIOD = 20;
    localparam int FIFO_DEPTH   = 16;

    localparam logic [31:0] A_UDATA = 32'h80000000;
    localparam logic [31:0] A_USTAT = 32'h80000004;
    localparam logic [31:0] A_LED   = 32'h80000010;
    localparam logic [31:0] A_BTN   = 32'h80000018;
    localparam logic [31:0] A_TCTRL = 32'h80000020;
    localparam logic [31:0] A_TPER  = 32'h80000024;
    localparam logic [31:0] A_TSTAT = 32'h8000002C;
    localparam logic [31:0] A_HOLE  = 32'h80000030;  // Gap between timer and soft IRQ
    localparam logic [31:0] A_SOFT  = 32'h80000040;

    logic        clk;
    logic        global_resetn;
    logic        mmio_valid;
    logic        mmio_write;
    logic [31:0] mmio_addr;
    logic [31:0] mmio_wdata;
    logic [3:0]  mmio_wstrb;
    logic [1:0]  buttons_n;
    logic [7:0]  rx_byte;
    logic        rx_valid;
    logic [31:0] mmio_rdata;
    logic        mmio_ready;
    logic [1:0]  leds;
    logic        soft_irq;
    logic        timer_irq;

    // Stimulus table, one entry per row in each queue
    int          row_op[$];
    logic [31:0] row_addr[$];
    logic [31:0] row_data[$];
    logic [3:0]  row_strb[$];
    logic [31:0] row_exp[$];
    string       row_name[$];

    logic [7:0]  model_q[$];                         // Bytes the FIFO should hold
    integer      seed = 32'h0f59c12e;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    mmio_subsystem_top dut_i (
        .clk(clk), .global_resetn(global_resetn),
        .mmio_valid(mmio_valid), .mmio_write(mmio_write), .mmio_addr(mmio_addr),
        .mmio_wdata(mmio_wdata), .mmio_wstrb(mmio_wstrb), .buttons_n(buttons_n),
        .rx_byte(rx_byte), .rx_valid(rx_valid),
        .mmio_rdata(mmio_rdata), .mmio_ready(mmio_ready),
        .leds(leds), .soft_irq(soft_irq), .timer_irq(timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                       // 10 ns period
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: bus or interrupt never arrived");
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic add_row(input int op, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [31:0] exp, input string name);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_strb.push_back(strb);
        row_exp.push_back(exp);
        row_name.push_back(name);
    endtask

    // ========================================================================
    // Stimulus table
    // ========================================================================
    task automatic build_table();
        add_row(OP_OUTS,   0,       0,  4'h0, 32'h0, "outputs idle after reset");
        add_row(OP_WRITE,  A_LED,   2,  4'hF, 32'h0, "led write");
        add_row(OP_OUTS,   0,       0,  4'h0, 32'h2, "led pins follow write");
        add_row(OP_READ,   A_LED,   0,  4'h0, 32'h2, "led readback");
        add_row(OP_WRITE,  A_LED,   1,  4'hE, 32'h0, "led write with lane 0 off");
        add_row(OP_READ,   A_LED,   0,  4'h0, 32'h2, "led unchanged");
        add_row(OP_BUTTON, 0,       1,  4'h0, 32'h0, "button 1 pressed");
        add_row(OP_WAIT,   0,       2,  4'h0, 32'h0, "button sync settle");
        add_row(OP_READ,   A_BTN,   0,  4'h0, 32'h2, "buttons read inverted");
        add_row(OP_WRITE,  A_SOFT,  0,  4'hF, 32'h1, "soft irq pulse");
        add_row(OP_PUSH,   0,       5,  4'h0, 32'h0, "push 5 bytes");
        add_row(OP_READ,   A_USTAT, 0,  4'h0, 32'h0, "status not empty");
        add_row(OP_POP,    A_UDATA, 5,  4'h0, 32'h0, "bytes in push order");
        add_row(OP_READ,   A_USTAT, 0,  4'h0, 32'h1, "status empty");
        add_row(OP_POP,    A_UDATA, 1,  4'h0, 32'h0, "empty data read is zero");
        add_row(OP_PUSH,   0,       18, 4'h0, 32'h0, "push 18 bytes");
        add_row(OP_READ,   A_USTAT, 0,  4'h0, 32'h2, "status full");
        add_row(OP_POP,    A_UDATA, 16, 4'h0, 32'h0, "first 16 bytes kept");
        add_row(OP_READ,   A_USTAT, 0,  4'h0, 32'h1, "overflow bytes lost");
        add_row(OP_WRITE,  A_TPER,  TIMER_PERIOD, 4'hF, 32'h0, "timer period");
        add_row(OP_WRITE,  A_TCTRL, 1,  4'hF, 32'h0, "timer enable");
        add_row(OP_TIRQ,   0,       TIMER_PERIOD - 1, 4'h0, 32'h0, "no tick before period");
        add_row(OP_TIRQ,   0,       1,  4'h0, 32'h1, "tick at period");
        add_row(OP_READ,   A_TSTAT, 0,  4'h0, 32'h1, "pending in status");
        add_row(OP_WRITE,  A_TSTAT, 1,  4'hF, 32'h0, "pending clear");
        add_row(OP_TIRQ,   0,       1,  4'h0, 32'h0, "timer irq dropped");
        add_row(OP_WRITE,  A_TCTRL, 0,  4'hF, 32'h0, "timer disable");
        add_row(OP_TIRQ,   0,       40, 4'h0, 32'h0, "quiet while disabled");
        add_row(OP_READ,   A_HOLE,  0,  4'h0, 32'h0, "unmapped read");
    endtask

    // Rough cycles per row, feeds the watchdog limit
    function automatic int row_cost(input int op, input int data);
        case (op)
            OP_WRITE, OP_READ:         return 3;
            OP_PUSH, OP_WAIT, OP_TIRQ: return data;
            OP_BUTTON:                 return 1;
            OP_POP:                    return 3 * data;
            default:                   return 0;
        endcase
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch %s: expected %h, got %h", sig, exp, act);
        errors++;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;                                          // Drive and sample point
    endtask

    // One bus transfer, holds the request until the cycle after ready
    task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, output logic [31:0] rdata,
                              output logic irq_at_ready, output logic irq_after);
        int lat;
        mmio_valid = 1'b1;
        mmio_write = wr;
        mmio_addr  = addr;
        mmio_wdata = wdata;
        mmio_wstrb = strb;
        step_cycle();
        lat = 1;
        while (!mmio_ready) begin
            step_cycle();
            lat++;
        end
        rdata        = mmio_rdata;
        irq_at_ready = soft_irq;
        checks += 2;
        if (lat != 1) begin
            $display("Bus ready for address %h came after %0d cycles instead of 1", addr, lat);
            errors++;
        end
        step_cycle();                                // Master sees ready here
        irq_after = soft_irq;
        if (mmio_ready) begin
            $display("Bus ready stayed high a second cycle for address %h", addr);
            errors++;
        end
        mmio_valid = 1'b0;
        mmio_write = 1'b0;
    endtask

    // Random bytes as one-cycle strobes
    task automatic push_bytes(input int n);
        logic [7:0] b;
        int         i;
        for (i = 0; i < n; i++) begin
            b        = $random(seed);
            rx_byte  = b;
            rx_valid = 1'b1;
            if (model_q.size() < FIFO_DEPTH) begin
                model_q.push_back(b);                // Full FIFO drops it
            end
            step_cycle();
        end
        rx_valid = 1'b0;
    endtask

    task automatic run_row(input int idx);
        logic [31:0] rd;
        logic        irq_rdy;
        logic        irq_next;
        logic [31:0] want;
        int          errs_before;
        int          i;
        errs_before = errors;
        case (row_op[idx])
            OP_WRITE: begin
                bus_access(1'b1, row_addr[idx], row_data[idx], row_strb[idx], rd, irq_rdy,
                           irq_next);
                if (irq_rdy !== row_exp[idx][0]) report_mismatch("soft_irq", row_exp[idx], irq_rdy);
                if (irq_next !== 1'b0) report_mismatch("soft_irq", 32'h0, irq_next);
            end
            OP_READ: begin
                bus_access(1'b0, row_addr[idx], 32'h0, 4'h0, rd, irq_rdy, irq_next);
                if (rd !== row_exp[idx]) report_mismatch("mmio_rdata", row_exp[idx], rd);
            end
            OP_PUSH:   push_bytes(row_data[idx]);
            OP_BUTTON: begin
                buttons_n = row_data[idx][1:0];
                step_cycle();
            end
            OP_WAIT:   repeat (row_data[idx]) step_cycle();
            OP_POP: begin
                for (i = 0; i < row_data[idx]; i++) begin
                    want = 32'h0;                    // Empty FIFO reads zero
                    if (model_q.size() > 0) begin
                        want = {24'h0, model_q.pop_front()};
                    end
                    bus_access(1'b0, row_addr[idx], 32'h0, 4'h0, rd, irq_rdy, irq_next);
                    if (rd !== want) report_mismatch("mmio_rdata", want, rd);
                end
            end
            OP_OUTS: begin
                checks++;
                if ({timer_irq, soft_irq, leds} !== row_exp[idx][3:0]) begin
                    report_mismatch("timer_irq/soft_irq/leds", row_exp[idx],
                                    {timer_irq, soft_irq, leds});
                end
            end
            OP_TIRQ: begin
                for (i = 0; i < row_data[idx]; i++) begin
                    checks++;
                    if (timer_irq !== row_exp[idx][0]) report_mismatch("timer_irq", row_exp[idx],
                                                                     timer_irq);
                    step_cycle();
                end
            end
            default: ;
        endcase
        $display("Test %0d %s: %s", idx, row_name[idx], (errors == errs_before) ? "ok" : "error");
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        int total;
        int i;
        global_resetn = 1'b0;
        mmio_valid    = 1'b0;
        mmio_write    = 1'b0;
        mmio_addr     = 32'h0;
        mmio_wdata    = 32'h0;
        mmio_wstrb    = 4'h0;
        buttons_n     = 2'b11;                       // Both released
        rx_byte       = 8'h0;
        rx_valid      = 1'b0;
        build_table();
        total = 3;                                   // Reset cycles
        for (i = 0; i < row_op.size(); i++) begin
            total += row_cost(row_op[i], row_data[i]);
        end
        cycle_limit = 2 * total + 2 * TIMER_PERIOD;
        repeat (3) @(posedge clk);
        #1;
        global_resetn = 1'b1;
        for (i = 0; i < row_op.size(); i++) begin
            run_row(i);
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", row_op.size(), checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
bus_pkg.sv
periph_pkg.sv
mmio_decode.sv
simple_io.sv
tick_timer.sv
rx_byte_fifo.sv
mmio_subsystem_top.sv
tb_mmio_subsystem.sv
